/* hw/periph_pkg.sv */
package periph_pkg;

    // --------------------
    // Register bus
    // --------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
        logic              error;
    } reg_rsp_t;

    // --------------------
    // Address map
    // --------------------
    localparam logic [3:0]        SEL_PLIC  = 4'h0; // addr[11:8]
    localparam logic [3:0]        SEL_TIMER = 4'h1;
    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

    localparam logic [7:0] PLIC_PRIO_OFS    = 8'h00; // one word per id
    localparam logic [7:0] PLIC_PENDING_OFS = 8'h20;
    localparam logic [7:0] PLIC_ENABLE_OFS  = 8'h24;
    localparam logic [7:0] PLIC_THRESH_OFS  = 8'h28;
    localparam logic [7:0] PLIC_CLAIM_OFS   = 8'h2C;

    localparam logic [7:0] TMR_COUNT_OFS  = 8'h0;
    localparam logic [7:0] TMR_CMP_OFS    = 8'h4;
    localparam logic [7:0] TMR_CTRL_OFS   = 8'h8;
    localparam logic [7:0] TMR_STATUS_OFS = 8'hC;
    localparam logic [7:0] TMR_STRIDE     = 8'h10;

    // --------------------
    // Interrupt sources
    // --------------------
    localparam int NUM_SOURCES = 8; // id 0 reserved
    localparam int SRC_ID_W    = 3;
    localparam int PRIO_W      = 3;
    localparam int NUM_TIMERS  = 2;
    localparam int NUM_EXT_IRQ = 4;
    localparam int SRC_TIMER0  = 1;
    localparam int SRC_EXT0    = 3;

endpackage

/* hw/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  periph_pkg::reg_req_t                reg_req_i,
    output periph_pkg::reg_rsp_t                reg_rsp_o,
    input  logic [periph_pkg::NUM_EXT_IRQ-1:0]  ext_irq_i,
    output logic                                irq_o
);
    import periph_pkg::*;

    reg_req_t plic_req;
    reg_rsp_t plic_rsp;
    reg_req_t timer_req;
    reg_rsp_t timer_rsp;

    logic [NUM_TIMERS-1:0]  timer_irq;
    logic [NUM_SOURCES-1:0] irq_src;

    // --------------------
    // Source numbering
    // --------------------
    assign irq_src[0]                          = 1'b0; // reserved
    assign irq_src[SRC_TIMER0 +: NUM_TIMERS]   = timer_irq;
    assign irq_src[SRC_EXT0 +: NUM_EXT_IRQ]    = ext_irq_i;
    assign irq_src[NUM_SOURCES-1]              = 1'b0;

    reg_demux i_reg_demux (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .req_i       ( reg_req_i ),
        .rsp_o       ( reg_rsp_o ),
        .plic_req_o  ( plic_req  ),
        .plic_rsp_i  ( plic_rsp  ),
        .timer_req_o ( timer_req ),
        .timer_rsp_i ( timer_rsp )
    );

    reg_timer i_reg_timer (
        .clk_i    ( clk_i     ),
        .arst_n_i ( arst_n_i  ),
        .req_i    ( timer_req ),
        .rsp_o    ( timer_rsp ),
        .irq_o    ( timer_irq )
    );

    plic_core i_plic_core (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .req_i    ( plic_req ),
        .rsp_o    ( plic_rsp ),
        .src_i    ( irq_src  ),
        .irq_o    ( irq_o    )
    );

endmodule

/* hw/plic_core.sv */
`timescale 1ns/1ps

module plic_core (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  periph_pkg::reg_req_t                req_i,
    output periph_pkg::reg_rsp_t                rsp_o,
    input  logic [periph_pkg::NUM_SOURCES-1:0]  src_i,
    output logic                                irq_o
);
    import periph_pkg::*;

    logic [PRIO_W-1:0]      prio_q [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] enable_q;
    logic [PRIO_W-1:0]      thresh_q;
    logic [NUM_SOURCES-1:0] pending;

    logic [7:0]          ofs;
    logic [7:0]          prio_ofs;
    logic                prio_hit;
    logic [SRC_ID_W-1:0] prio_id;
    logic                rd;
    logic                wr;
    logic [SRC_ID_W-1:0] sel_id;
    logic [PRIO_W-1:0]   sel_prio;
    logic [DATA_W-1:0]   rdata;

    assign ofs      = req_i.addr[7:0];
    assign prio_ofs = ofs - PLIC_PRIO_OFS;
    assign prio_hit = prio_ofs < 8'(4 * NUM_SOURCES);
    assign prio_id  = prio_ofs[2 +: SRC_ID_W];
    assign rd       = req_i.valid && !req_i.write;
    assign wr       = req_i.valid && req_i.write;

    // --------------------
    // Config registers
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_SOURCES; i++) prio_q[i] <= '0;
            enable_q <= '0;
            thresh_q <= '0;
        end else if (wr) begin
            if (prio_hit) prio_q[prio_id] <= req_i.wdata[PRIO_W-1:0];
            if (ofs == PLIC_ENABLE_OFS) enable_q <= req_i.wdata[NUM_SOURCES-1:0];
            if (ofs == PLIC_THRESH_OFS) thresh_q <= req_i.wdata[PRIO_W-1:0];
        end
    end

    // Strictly above threshold, lowest id wins a tie
    always_comb begin
        sel_id   = '0;
        sel_prio = thresh_q;
        for (int i = 1; i < NUM_SOURCES; i++) begin
            if (pending[i] && enable_q[i] && prio_q[i] > sel_prio) begin
                sel_id   = SRC_ID_W'(i);
                sel_prio = prio_q[i];
            end
        end
    end

    assign irq_o = (sel_id != '0);

    plic_gateway i_plic_gateway (
        .clk_i         ( clk_i                                    ),
        .arst_n_i      ( arst_n_i                                 ),
        .src_i         ( src_i                                    ),
        .claim_i       ( rd && ofs == PLIC_CLAIM_OFS && irq_o     ),
        .claim_id_i    ( sel_id                                   ),
        .complete_i    ( wr && ofs == PLIC_CLAIM_OFS              ),
        .complete_id_i ( req_i.wdata[SRC_ID_W-1:0]                ),
        .pending_o     ( pending                                  )
    );

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        rdata = '0;
        if (prio_hit) begin
            rdata[PRIO_W-1:0] = prio_q[prio_id];
        end else begin
            case (ofs)
                PLIC_PENDING_OFS: rdata[NUM_SOURCES-1:0] = pending;
                PLIC_ENABLE_OFS:  rdata[NUM_SOURCES-1:0] = enable_q;
                PLIC_THRESH_OFS:  rdata[PRIO_W-1:0]      = thresh_q;
                PLIC_CLAIM_OFS:   rdata[SRC_ID_W-1:0]    = sel_id;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_o <= '0;
        end else begin
            rsp_o.valid <= req_i.valid;
            rsp_o.rdata <= rd ? rdata : '0;
            rsp_o.error <= 1'b0;
        end
    end

endmodule

/* hw/plic_gateway.sv */
`timescale 1ns/1ps

module plic_gateway (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [periph_pkg::NUM_SOURCES-1:0]  src_i,
    input  logic                                claim_i,
    input  logic [periph_pkg::SRC_ID_W-1:0]     claim_id_i,
    input  logic                                complete_i,
    input  logic [periph_pkg::SRC_ID_W-1:0]     complete_id_i,
    output logic [periph_pkg::NUM_SOURCES-1:0]  pending_o
);
    import periph_pkg::*;

    logic [NUM_SOURCES-1:0] pending_q;
    logic [NUM_SOURCES-1:0] in_service_q;

    // --------------------
    // Level gateway
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            // Id 0 never becomes pending
            for (int i = 1; i < NUM_SOURCES; i++) begin
                if (claim_i && claim_id_i == i) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else begin
                    // Held off while in service
                    if (src_i[i] && !in_service_q[i]) begin
                        pending_q[i] <= 1'b1;
                    end
                    if (complete_i && complete_id_i == i) begin
                        in_service_q[i] <= 1'b0; // no-op if idle
                    end
                end
            end
        end
    end

    assign pending_o = pending_q;

endmodule

/* hw/reg_demux.sv */
`timescale 1ns/1ps

module reg_demux (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  periph_pkg::reg_req_t req_i,
    output periph_pkg::reg_rsp_t rsp_o,
    output periph_pkg::reg_req_t plic_req_o,
    input  periph_pkg::reg_rsp_t plic_rsp_i,
    output periph_pkg::reg_req_t timer_req_o,
    input  periph_pkg::reg_rsp_t timer_rsp_i
);
    import periph_pkg::*;

    logic [3:0] sel;
    logic       hit_plic;
    logic       hit_timer;
    logic       err_q;
    reg_rsp_t   err_rsp;

    assign sel       = req_i.addr[ADDR_W-1 -: 4];
    assign hit_plic  = (sel == SEL_PLIC);
    assign hit_timer = (sel == SEL_TIMER);

    // --------------------
    // Strobe routing
    // --------------------
    always_comb begin
        plic_req_o        = req_i;
        plic_req_o.valid  = req_i.valid && hit_plic;
        timer_req_o       = req_i;
        timer_req_o.valid = req_i.valid && hit_timer;
    end

    // No peripheral behind this selection
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i.valid && !hit_plic && !hit_timer;
        end
    end

    always_comb begin
        err_rsp.valid = err_q;
        err_rsp.rdata = err_q ? ERR_RDATA : '0;
        err_rsp.error = err_q;
    end

    // Only one responder per cycle, others drive zero
    assign rsp_o = plic_rsp_i | timer_rsp_i | err_rsp;

endmodule

/* hw/reg_timer.sv */
`timescale 1ns/1ps

module reg_timer (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  periph_pkg::reg_req_t              req_i,
    output periph_pkg::reg_rsp_t              rsp_o,
    output logic [periph_pkg::NUM_TIMERS-1:0] irq_o
);
    import periph_pkg::*;

    logic [DATA_W-1:0]     count_q [NUM_TIMERS];
    logic [DATA_W-1:0]     cmp_q   [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] en_q;
    logic [NUM_TIMERS-1:0] status_q;

    logic [7:0]        ch;
    logic [7:0]        ofs;
    logic              wr;
    logic [DATA_W-1:0] rdata;

    assign ch  = req_i.addr[7:0] / TMR_STRIDE;
    assign ofs = req_i.addr[7:0] % TMR_STRIDE;
    assign wr  = req_i.valid && req_i.write;

    // --------------------
    // Channels
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
            en_q     <= '0;
            status_q <= '0;
        end else begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (en_q[i]) begin
                    if (count_q[i] == cmp_q[i]) begin
                        count_q[i]  <= '0;
                        status_q[i] <= 1'b1; // sticky
                    end else begin
                        count_q[i] <= count_q[i] + 1'b1;
                    end
                end
                // Bus write takes precedence over the count event
                if (wr && ch == i) begin
                    case (ofs)
                        TMR_COUNT_OFS:  count_q[i] <= req_i.wdata;
                        TMR_CMP_OFS:    cmp_q[i]   <= req_i.wdata;
                        TMR_CTRL_OFS:   en_q[i]    <= req_i.wdata[0];
                        TMR_STATUS_OFS: if (req_i.wdata[0]) status_q[i] <= 1'b0; // W1C
                        default: ;
                    endcase
                end
            end
        end
    end

    // Unmapped offsets read zero
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (ch == i) begin
                case (ofs)
                    TMR_COUNT_OFS:  rdata = count_q[i];
                    TMR_CMP_OFS:    rdata = cmp_q[i];
                    TMR_CTRL_OFS:   rdata = {{(DATA_W-1){1'b0}}, en_q[i]};
                    TMR_STATUS_OFS: rdata = {{(DATA_W-1){1'b0}}, status_q[i]};
                    default:        rdata = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_o <= '0;
        end else begin
            rsp_o.valid <= req_i.valid;
            rsp_o.rdata <= (req_i.valid && !req_i.write) ? rdata : '0;
            rsp_o.error <= 1'b0;
        end
    end

    assign irq_o = status_q;

endmodule

/* sources.f */
+incdir+verif
hw/periph_pkg.sv
hw/plic_gateway.sv
hw/plic_core.sv
hw/reg_timer.sv
hw/reg_demux.sv
hw/periph_top.sv
verif/tb_periph_top.sv

/* verif/tb_periph_tasks.svh */
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

int    errors;
int    err_mark;
int    tests_run;
int    tests_failed;
string test_name;

task automatic flag_error(input string what);
    $display("CHECK FAILED @%0t: %s", $time, what);
    errors++;
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else flag_error($sformatf("%s is %h, expected %h", what, got, exp));
endtask

task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors != err_mark) begin
        tests_failed++;
    end
    $display("test %0d, %s: %0d errors", tests_run, test_name, errors - err_mark);
endtask

// --------------------
// Register bus
// --------------------
task automatic bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic error);
    int cnt;
    @(posedge clk_i);
    #1;
    reg_req_i = '{1'b1, wr, addr, wdata};
    @(posedge clk_i);
    #1;
    reg_req_i.valid = 1'b0; // single-cycle strobe
    for (cnt = 0; !reg_rsp_o.valid; cnt++) begin
        if (cnt == TIMEOUT_CYC) abort_run("no bus response arrived");
        @(posedge clk_i);
        #1;
    end
    rdata = reg_rsp_o.rdata;
    error = reg_rsp_o.error;
endtask

// Mapped register access with the expected read data
task automatic reg_access(input logic wr, input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        error;
    bus_access(wr, addr, data, rdata, error);
    check_value(32'(error), 0, $sformatf("error flag at %h", addr));
    if (!wr) begin
        check_value(rdata, data, $sformatf("read of %h", addr));
    end
endtask

task automatic wait_irq(input logic level, input string what);
    int cnt;
    for (cnt = 0; irq_o !== level; cnt++) begin
        if (cnt == TIMEOUT_CYC) abort_run(what);
        @(posedge clk_i);
        #1;
    end
endtask

`endif

/* verif/tb_periph_top.sv */
`timescale 1ns/1ps

module tb_periph_top;
    import periph_pkg::*;

    localparam int          TIMEOUT_CYC = 200;
    localparam logic [11:0] ENABLE_ADDR = {SEL_PLIC, PLIC_ENABLE_OFS};
    localparam logic [11:0] THRESH_ADDR = {SEL_PLIC, PLIC_THRESH_OFS};
    localparam logic [11:0] CLAIM_ADDR  = {SEL_PLIC, PLIC_CLAIM_OFS};

    logic                   clk_i;
    logic                   arst_n_i;
    reg_req_t               reg_req_i;
    reg_rsp_t               reg_rsp_o;
    logic [NUM_EXT_IRQ-1:0] ext_irq_i;
    logic                   irq_o;
    integer                 seed = 32'hff87254a;

    `include "tb_periph_tasks.svh"

    periph_top dut (.*);

    always #5 clk_i = ~clk_i;

    // Exactly one response per strobe, one cycle later
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     reg_req_i.valid |=> reg_rsp_o.valid)
        else flag_error("no response one cycle after a request strobe");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     reg_rsp_o.valid |-> $past(reg_req_i.valid))
        else flag_error("response valid without a request one cycle before");

    function automatic logic [11:0] prio_addr(input int id);
        return {SEL_PLIC, 8'(PLIC_PRIO_OFS + 4 * id)};
    endfunction

    function automatic logic [11:0] tmr_addr(input int ch, input logic [7:0] ofs);
        return {SEL_TIMER, 8'(TMR_STRIDE * ch + ofs)};
    endfunction

    // Highest priority above the threshold, lowest id on a tie
    function automatic int pick_winner(input logic [7:0] active, input int prio [8],
                                       input int thresh);
        int best;
        best = 0;
        for (int id = NUM_SOURCES - 1; id > 0; id--) begin
            if (active[id] && prio[id] > thresh && (best == 0 || prio[id] >= prio[best])) begin
                best = id;
            end
        end
        return best;
    endfunction

    task automatic abort_run(input string what);
        $display("Run aborted: %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        error;
        logic [31:0] wr_val [8];
        logic [31:0] cmp_val [2];
        int          prio [8];
        logic [7:0]  active;
        int          id;

        clk_i     = 1'b0;
        arst_n_i  = 1'b0;
        reg_req_i = '0;
        ext_irq_i = '0;
        repeat (10) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        begin_test("reset and response timing");
        check_value(32'(irq_o), 0, "irq_o after reset");
        reg_access(1'b0, {SEL_PLIC, PLIC_PENDING_OFS}, 0);
        reg_access(1'b0, tmr_addr(0, TMR_COUNT_OFS), 0);
        reg_access(1'b0, tmr_addr(1, TMR_COUNT_OFS), 0);
        end_test();

        begin_test("unmapped address");
        bus_access(1'b0, 12'h210, 0, rdata, error);
        check_value(rdata, 32'hdeadbeef, "unmapped read data");
        check_value(32'(error), 1, "unmapped read error");
        bus_access(1'b1, 12'h204, 32'h1234_5678, rdata, error);
        check_value(32'(error), 1, "unmapped write error");
        end_test();

        // --------------------
        // Register readback
        // --------------------
        begin_test("register readback");
        for (id = 1; id < NUM_SOURCES; id++) begin
            wr_val[id] = $random(seed);
            reg_access(1'b1, prio_addr(id), wr_val[id]);
        end
        for (id = 0; id < NUM_TIMERS; id++) begin
            cmp_val[id] = $random(seed);
            reg_access(1'b1, tmr_addr(id, TMR_CMP_OFS), cmp_val[id]);
        end
        reg_access(1'b1, ENABLE_ADDR, 32'h5a);
        reg_access(1'b1, THRESH_ADDR, 32'h5);
        for (id = 1; id < NUM_SOURCES; id++) begin
            reg_access(1'b0, prio_addr(id), wr_val[id] & 32'h7); // 3-bit field
        end
        for (id = 0; id < NUM_TIMERS; id++) begin
            reg_access(1'b0, tmr_addr(id, TMR_CMP_OFS), cmp_val[id]);
        end
        reg_access(1'b0, ENABLE_ADDR, 32'h5a);
        reg_access(1'b0, THRESH_ADDR, 32'h5);
        end_test();

        begin_test("timer interrupt");
        reg_access(1'b1, prio_addr(SRC_TIMER0), 1);
        reg_access(1'b1, ENABLE_ADDR, 32'h1 << SRC_TIMER0);
        reg_access(1'b1, THRESH_ADDR, 0);
        reg_access(1'b1, tmr_addr(0, TMR_CMP_OFS), 5);
        reg_access(1'b1, tmr_addr(0, TMR_CTRL_OFS), 1);
        wait_irq(1'b1, "timer 0 never raised irq_o");
        reg_access(1'b0, CLAIM_ADDR, SRC_TIMER0);
        reg_access(1'b1, tmr_addr(0, TMR_CTRL_OFS), 0);
        reg_access(1'b1, tmr_addr(0, TMR_STATUS_OFS), 1);
        reg_access(1'b1, CLAIM_ADDR, SRC_TIMER0);
        reg_access(1'b0, tmr_addr(0, TMR_STATUS_OFS), 0);
        check_value(32'(irq_o), 0, "irq_o after timer completion");
        end_test();

        // --------------------
        // Arbitration
        // --------------------
        begin_test("arbitration and threshold");
        for (id = SRC_EXT0; id < SRC_EXT0 + NUM_EXT_IRQ; id++) begin
            prio[id] = 1 + ($unsigned($random(seed)) % 7);
            reg_access(1'b1, prio_addr(id), prio[id]);
        end
        reg_access(1'b1, ENABLE_ADDR, 32'h78);
        reg_access(1'b1, THRESH_ADDR, 7);
        ext_irq_i = '1;
        reg_access(1'b0, {SEL_PLIC, PLIC_PENDING_OFS}, 32'h78);
        repeat (8) begin
            @(posedge clk_i);
            #1;
            check_value(32'(irq_o), 0, "irq_o with threshold 7");
        end
        reg_access(1'b1, THRESH_ADDR, 0);
        active = 8'h78;
        repeat (NUM_EXT_IRQ) begin
            id = pick_winner(active, prio, 0);
            wait_irq(1'b1, "pending external source did not raise irq_o");
            reg_access(1'b0, CLAIM_ADDR, id);
            ext_irq_i[id - SRC_EXT0] = 1'b0; // released before its completion
            active[id] = 1'b0;
            reg_access(1'b1, CLAIM_ADDR, id);
        end
        check_value(32'(irq_o), 0, "irq_o after all claims");
        end_test();

        begin_test("gateway in-service rule");
        reg_access(1'b1, prio_addr(SRC_EXT0), 2);
        reg_access(1'b1, ENABLE_ADDR, 32'h1 << SRC_EXT0);
        ext_irq_i[0] = 1'b1;
        wait_irq(1'b1, "external source 0 did not raise irq_o");
        reg_access(1'b0, CLAIM_ADDR, SRC_EXT0);
        check_value(32'(irq_o), 0, "irq_o while in service");
        reg_access(1'b0, CLAIM_ADDR, 0); // source still high
        check_value(32'(irq_o), 0, "irq_o while in service");
        reg_access(1'b1, CLAIM_ADDR, SRC_EXT0);
        wait_irq(1'b1, "irq_o did not return after completion");
        reg_access(1'b0, CLAIM_ADDR, SRC_EXT0);
        ext_irq_i[0] = 1'b0;
        reg_access(1'b1, CLAIM_ADDR, SRC_EXT0);
        check_value(32'(irq_o), 0, "irq_o after release");
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
